/* common/rtg_params.svh */
// RTG sizes and OSD shades. FIFO depth and address width must agree
// CLUT index is 8 bits wide, so the entry count stays at 256
`ifndef RTG_PARAMS_SVH
`define RTG_PARAMS_SVH

// Pixel word FIFO
`define RTG_FIFO_DEPTH 16
`define RTG_FIFO_AW 4

// Palette
`define RTG_CLUT_ENTRIES 256

// OSD colour levels, top two bits of each component
`define RTG_OSD_SHADE_ON 2'b11
`define RTG_OSD_SHADE_OFF_RG 2'b00
`define RTG_OSD_SHADE_OFF_B 2'b10

`endif

/* common/rtg_pkg.sv */
// Shared RTG video types. All structs are packed MSB first
// The FIFO word is fixed at 16 bits, one hi-colour pixel or two CLUT indices
`default_nettype none

package rtg_pkg;

  typedef struct packed {
    logic [7:0] r;                   // Red
    logic [7:0] g;                   // Green
    logic [7:0] b;                   // Blue
  } rgb24_t;

  // RGB555 view of a FIFO word
  typedef struct packed {
    logic       pad;                 // Ignored top bit
    logic [4:0] r;
    logic [4:0] g;
    logic [4:0] b;
  } hicolor_t;

  // Indexed view of a FIFO word, high byte shown first
  typedef struct packed {
    logic [7:0] idx_hi;
    logic [7:0] idx_lo;
  } clut_pair_t;

  typedef union packed {
    hicolor_t   hicolor;
    clut_pair_t clut;
  } rtg_word_u;

  typedef struct packed {
    logic       ena;                 // RTG screen on
    logic       clut_mode;           // 8-bit indexed instead of hi-colour
    logic       ext;                 // One extra fetch past hblank
    logic [3:0] pixel_width;         // Clocks per fetch minus one
    logic [6:0] vb_end;              // Extra blank lines after vblank
  } rtg_cfg_t;

  typedef struct packed {
    rgb24_t rgb;
    logic   hs;
    logic   vs;
    logic   cs;
    logic   hblank;
    logic   vblank;
  } native_video_t;

  typedef struct packed {
    rgb24_t rgb;
    logic   hs;
    logic   vs;
    logic   cs;
  } video_out_t;

  typedef struct packed {
    logic       we;                  // Write strobe
    logic [7:0] idx;                 // Palette entry
    rgb24_t     rgb;
  } clut_wr_t;

  typedef enum logic [1:0] {
    IDLE,                            // RTG off or waiting for frame start
    VBLANK,                          // Chipset vblank, FIFO flushed
    VB_COUNT,                        // Counting extra blank lines
    ACTIVE                           // RTG picture shown
  } blank_state_e;

endpackage

`default_nettype wire

/* rtg/rtg_clut.sv */
// 256-entry palette RAM, one write and one registered read port
// Contents undefined until written
`default_nettype none

`include "rtg_params.svh"

module rtg_clut
  import rtg_pkg::*;
(
  input  wire logic       clk_114,
  input  wire clut_wr_t   clut_wr,
  input  wire logic [7:0] rd_idx,
  output rgb24_t          rd_rgb
);

  rgb24_t mem [`RTG_CLUT_ENTRIES];   // Palette entries

  always_ff @(posedge clk_114) begin
    if (clut_wr.we) begin
      mem[clut_wr.idx] <= clut_wr.rgb;
    end
    rd_rgb <= mem[rd_idx];             // One cycle read latency
  end

endmodule

`default_nettype wire

/* rtg/rtg_fifo.sv */
// Pixel word FIFO. Writes while full are dropped, reads while empty repeat q
// Flush wins over fill and fetch in the same cycle
`default_nettype none

`include "rtg_params.svh"

module rtg_fifo
  import rtg_pkg::*;
(
  input  wire logic        clk_114,
  input  wire logic        arst_n,
  input  wire logic        fill,
  input  wire logic [15:0] fill_data,
  input  wire logic        fetch,
  input  wire logic        flush,
  input  wire logic        rtg_active,
  output rtg_word_u        q,
  output logic             fill_req
);

  localparam logic [`RTG_FIFO_AW:0] LVL_FULL = (`RTG_FIFO_AW + 1)'(`RTG_FIFO_DEPTH);
  localparam logic [`RTG_FIFO_AW:0] LVL_HALF = (`RTG_FIFO_AW + 1)'(`RTG_FIFO_DEPTH / 2);

  logic [15:0]             mem [`RTG_FIFO_DEPTH];
  logic [`RTG_FIFO_AW-1:0] wr_ptr;
  logic [`RTG_FIFO_AW-1:0] rd_ptr;
  logic [`RTG_FIFO_AW:0]   level;    // Words held
  logic                    full;
  logic                    empty;
  logic                    wr_en;
  logic                    rd_en;

  assign full  = (level == LVL_FULL);
  assign empty = (level == '0);
  assign wr_en = fill & ~full & ~flush;
  assign rd_en = fetch & ~empty & ~flush;

  ////////////////////////////////////////////////////////////////////////
  // Pointers and level
  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else if (flush) begin
      wr_ptr <= '0;                    // Frame start, drop old words
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      unique case ({wr_en, rd_en})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Storage and registered read
  always_ff @(posedge clk_114) begin
    if (wr_en) mem[wr_ptr] <= fill_data;
    if (rd_en) q <= mem[rd_ptr];       // Holds last word when empty
  end

  // Ask the memory side for more while below half
  assign fill_req = rtg_active & (level < LVL_HALF);

endmodule

`default_nettype wire

/* rtg/rtg_pixel_decode.sv */
// FIFO word decode. Output is one cycle behind q in both modes
// blank_d lines up with rtg_rgb for the mixer
`default_nettype none

module rtg_pixel_decode
  import rtg_pkg::*;
(
  input  wire logic      clk_114,
  input  wire logic      arst_n,
  input  wire rtg_cfg_t  cfg,
  input  wire rtg_word_u q,
  input  wire logic      clut_sel,
  input  wire logic      blank,
  input  wire rgb24_t    clut_rgb,
  output logic [7:0]     clut_rd_idx,
  output rgb24_t         rtg_rgb,
  output logic           blank_d
);

  rgb24_t hc_rgb;                    // Expanded hi-colour, aligned with CLUT
  logic   blank_d1;

  // Top bits repeated into the low end, so full scale stays full scale
  function automatic logic [7:0] expand5(input logic [4:0] c);
    return {c, c[4:2]};
  endfunction

  // clut_sel clears together with the q update, so the index follows q
  assign clut_rd_idx = clut_sel ? q.clut.idx_lo : q.clut.idx_hi;

  always_ff @(posedge clk_114) begin
    hc_rgb.r <= expand5(q.hicolor.r);
    hc_rgb.g <= expand5(q.hicolor.g);
    hc_rgb.b <= expand5(q.hicolor.b);
  end

  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      blank_d1   <= 1'b1;
      blank_d    <= 1'b1;
    end else begin
      blank_d1   <= blank;             // q stage
      blank_d    <= blank_d1;          // Colour stage
    end
  end

  assign rtg_rgb = cfg.clut_mode ? clut_rgb : hc_rgb;

endmodule

`default_nettype wire

/* rtg_video.f */
+incdir+common
common/rtg_pkg.sv
rtl/rtg_blank_fsm.sv
rtl/rtg_fetch_timer.sv
rtg/rtg_fifo.sv
rtg/rtg_clut.sv
rtg/rtg_pixel_decode.sv
rtl/video_mixer.sv
rtl/rtg_video_top.sv
verification/rtg_video_assert.sv
verification/rtg_video_tb.sv

/* rtl/rtg_blank_fsm.sv */
// RTG frame state. Needs ena static within a frame
// Line count saturates at vb_end, larger counts than 127 are not possible
`default_nettype none

module rtg_blank_fsm
  import rtg_pkg::*;
(
  input  wire logic     clk_114,
  input  wire logic     arst_n,
  input  wire rtg_cfg_t cfg,
  input  wire logic     native_hs,
  input  wire logic     native_vblank,
  input  wire logic     native_hblank,
  output logic          blank,
  output logic          rtg_active,
  output logic          flush
);

  blank_state_e state;
  blank_state_e state_nxt;
  logic [6:0]   line_cnt;            // Extra lines seen so far
  logic         hs_d;
  logic         hs_rise;

  assign hs_rise = native_hs & ~hs_d;

  always_comb begin
    state_nxt = state;
    if (!cfg.ena) begin
      state_nxt = IDLE;
    end else if (native_vblank) begin
      state_nxt = VBLANK;              // Restart every frame
    end else begin
      unique case (state)
        IDLE:     state_nxt = IDLE;    // Wait for the first vblank
        VBLANK:   state_nxt = VB_COUNT;
        VB_COUNT: if (line_cnt == cfg.vb_end) state_nxt = ACTIVE;
        ACTIVE:   state_nxt = ACTIVE;
      endcase
    end
  end

  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      state    <= IDLE;
      line_cnt <= '0;
      hs_d     <= 1'b0;
    end else begin
      state <= state_nxt;
      hs_d  <= native_hs;
      if (state != VB_COUNT) begin
        line_cnt <= '0;                // Fresh count each frame
      end else if (hs_rise && line_cnt != cfg.vb_end) begin
        line_cnt <= line_cnt + 1'b1;
      end
    end
  end

  assign blank      = (state != ACTIVE) | native_hblank;
  assign rtg_active = cfg.ena & (state != IDLE);
  assign flush      = (state == IDLE) | (state == VBLANK);

endmodule

`default_nettype wire

/* rtl/rtg_fetch_timer.sv */
// Fetch pacing for the RTG FIFO. pixel_width must not change mid-line
// clut_sel splits each fetch period in two halves for indexed mode
`default_nettype none

module rtg_fetch_timer
  import rtg_pkg::*;
(
  input  wire logic     clk_114,
  input  wire logic     arst_n,
  input  wire rtg_cfg_t cfg,
  input  wire logic     blank,
  input  wire logic     rtg_active,
  output logic          fetch,
  output logic          clut_sel,
  output logic          pixel_strobe
);

  logic [3:0] pix_cnt;               // Clocks since last fetch
  logic [3:0] half_cnt;
  logic       blank_q;               // Blank one cycle ago
  logic       fetch_d;
  logic       clut_sel_d;
  logic       clut_rise;

  assign half_cnt  = {1'b0, cfg.pixel_width[3:1]};
  assign clut_rise = clut_sel & ~clut_sel_d;

  // Ext lets one more fetch through just after blank rises
  assign fetch = rtg_active & (pix_cnt == cfg.pixel_width) &
                 (~blank | (~blank_q & cfg.ext));

  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      pix_cnt    <= '0;
      clut_sel   <= 1'b0;
      blank_q    <= 1'b1;
      fetch_d    <= 1'b0;
      clut_sel_d <= 1'b0;
    end else begin
      blank_q    <= blank;
      fetch_d    <= fetch;
      clut_sel_d <= clut_sel;
      if (blank || fetch) begin
        pix_cnt  <= '0;
        clut_sel <= 1'b0;
      end else begin
        pix_cnt <= pix_cnt + 1'b1;
        if (pix_cnt == half_cnt) clut_sel <= 1'b1;   // Second byte from here
      end
    end
  end

  // New pixel on each word, plus mid-word in CLUT mode
  assign pixel_strobe = rtg_active ? (fetch_d | (clut_rise & cfg.clut_mode)) : 1'b1;

endmodule

`default_nettype wire

/* rtl/rtg_video_top.sv */
// RTG video path, all on clk_114. Native video must arrive on clk_114
// fill, fill_req and the CLUT write are plain strobes without handshake
`default_nettype none

module rtg_video_top
  import rtg_pkg::*;
(
  input  wire logic          clk_114,
  input  wire logic          arst_n,
  input  wire rtg_cfg_t      cfg,          // Static within a frame
  input  wire native_video_t native,
  input  wire logic          osd_window,
  input  wire logic          osd_pixel,
  input  wire logic          fill,         // Memory write strobe
  input  wire logic [15:0]   fill_data,
  input  wire clut_wr_t      clut_wr,
  output video_out_t         video_out,
  output logic               pixel_strobe,
  output logic               fill_req
);

  logic       blank;
  logic       rtg_active;
  logic       flush;
  logic       fetch;
  logic       clut_sel;
  rtg_word_u  q;
  logic [7:0] clut_rd_idx;
  rgb24_t     clut_rgb;
  rgb24_t     rtg_rgb;
  logic       blank_d;

  ////////////////////////////////////////////////////////////////////////
  // Timing
  rtg_blank_fsm i_blank_fsm (
    .clk_114       (clk_114),
    .arst_n        (arst_n),
    .cfg           (cfg),
    .native_hs     (native.hs),
    .native_vblank (native.vblank),
    .native_hblank (native.hblank),
    .blank         (blank),
    .rtg_active    (rtg_active),
    .flush         (flush)
  );

  rtg_fetch_timer i_fetch_timer (
    .clk_114      (clk_114),
    .arst_n       (arst_n),
    .cfg          (cfg),
    .blank        (blank),
    .rtg_active   (rtg_active),
    .fetch        (fetch),
    .clut_sel     (clut_sel),
    .pixel_strobe (pixel_strobe)
  );

  ////////////////////////////////////////////////////////////////////////
  // Data path
  rtg_fifo i_fifo (
    .clk_114    (clk_114),
    .arst_n     (arst_n),
    .fill       (fill),
    .fill_data  (fill_data),
    .fetch      (fetch),
    .flush      (flush),
    .rtg_active (rtg_active),
    .q          (q),
    .fill_req   (fill_req)
  );

  rtg_clut i_clut (
    .clk_114 (clk_114),
    .clut_wr (clut_wr),
    .rd_idx  (clut_rd_idx),
    .rd_rgb  (clut_rgb)
  );

  rtg_pixel_decode i_pixel_decode (
    .clk_114     (clk_114),
    .arst_n      (arst_n),
    .cfg         (cfg),
    .q           (q),
    .clut_sel    (clut_sel),
    .blank       (blank),
    .clut_rgb    (clut_rgb),
    .clut_rd_idx (clut_rd_idx),
    .rtg_rgb     (rtg_rgb),
    .blank_d     (blank_d)
  );

  video_mixer i_video_mixer (
    .clk_114    (clk_114),
    .arst_n     (arst_n),
    .native     (native),
    .rtg_rgb    (rtg_rgb),
    .blank_d    (blank_d),
    .rtg_active (rtg_active),
    .osd_window (osd_window),
    .osd_pixel  (osd_pixel),
    .video_out  (video_out)
  );

endmodule

`default_nettype wire

/* rtl/video_mixer.sv */
// RTG or native colour select with OSD overlay, one register stage
// Syncs pass through with the same single cycle delay
`default_nettype none

`include "rtg_params.svh"

module video_mixer
  import rtg_pkg::*;
(
  input  wire logic          clk_114,
  input  wire logic          arst_n,
  input  wire native_video_t native,
  input  wire rgb24_t        rtg_rgb,
  input  wire logic          blank_d,
  input  wire logic          rtg_active,
  input  wire logic          osd_window,
  input  wire logic          osd_pixel,
  output video_out_t         video_out
);

  rgb24_t     mix_rgb;               // After RTG select
  rgb24_t     osd_rgb;               // After OSD overlay
  logic [1:0] shade_rg;
  logic [1:0] shade_b;

  assign mix_rgb = (rtg_active && !blank_d) ? rtg_rgb : native.rgb;

  // Blue keeps a tint when the OSD pixel is off
  assign shade_rg = osd_pixel ? `RTG_OSD_SHADE_ON : `RTG_OSD_SHADE_OFF_RG;
  assign shade_b  = osd_pixel ? `RTG_OSD_SHADE_ON : `RTG_OSD_SHADE_OFF_B;

  always_comb begin
    osd_rgb = mix_rgb;
    if (osd_window) begin
      osd_rgb.r = {shade_rg, mix_rgb.r[7:2]};
      osd_rgb.g = {shade_rg, mix_rgb.g[7:2]};
      osd_rgb.b = {shade_b, mix_rgb.b[7:2]};
    end
  end

  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      video_out <= '0;
    end else begin
      video_out.rgb <= osd_rgb;
      video_out.hs  <= native.hs;
      video_out.vs  <= native.vs;
      video_out.cs  <= native.cs;
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the RTG video testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f rtg_video.f --top-module rtg_video_tb -o rtg_video_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/rtg_video_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "All tests passed!"; then
  exit 0
fi
exit 1

/* verification/rtg_video_assert.sv */
// Protocol checks for the RTG video top, bound in from the testbench side
// Sampled on clk_114 and idle while reset is low
`default_nettype none

module rtg_video_assert
  import rtg_pkg::*;
(
  input wire logic     clk_114,
  input wire logic     arst_n,
  input wire rtg_cfg_t cfg,
  input wire logic     pixel_strobe,
  input wire logic     fill_req,
  input wire logic     fill
);

  // RTG off means every clock is a native pixel
  strobe_when_off: assert property (@(posedge clk_114) disable iff (!arst_n)
    !cfg.ena |-> pixel_strobe)
    else $error("pixel_strobe low while RTG is disabled");

  // No memory requests without RTG
  no_req_when_off: assert property (@(posedge clk_114) disable iff (!arst_n)
    !cfg.ena |-> !fill_req)
    else $error("fill_req high while RTG is disabled");

  // Source must respect the only back-pressure
  fill_only_on_req: assert property (@(posedge clk_114) disable iff (!arst_n)
    fill |-> fill_req)
    else $error("fill pulsed while fill_req was low");

endmodule

bind rtg_video_top rtg_video_assert i_assert (
  .clk_114      (clk_114),
  .arst_n       (arst_n),
  .cfg          (cfg),
  .pixel_strobe (pixel_strobe),
  .fill_req     (fill_req),
  .fill         (fill)
);

`default_nettype wire

/* verification/rtg_video_tb.sv */
// Directed tests for the RTG video path, all stimulus on clk_114
// Colour checks on RTG use ordered distinct colours, not exact cycle counts
`default_nettype none

`include "rtg_params.svh"

module rtg_video_tb
  import rtg_pkg::*;
;

  localparam int N_RAND    = 24;                       // Samples in native tests
  localparam int COLLECT   = 100;                      // Cycles watched per RTG frame
  localparam int LEN_TESTS = 4 + 4 * N_RAND + 2 * (40 + 2 * COLLECT) + 300 + 60;
  localparam int LIMIT     = 2 * LEN_TESTS;

  logic          clk_114;
  logic          arst_n;
  rtg_cfg_t      cfg;
  native_video_t native;
  logic          osd_window;
  logic          osd_pixel;
  logic          fill;
  logic [15:0]   fill_data;
  clut_wr_t      clut_wr;
  video_out_t    video_out;
  logic          pixel_strobe;
  logic          fill_req;

  int            errors;
  int            checks;
  int            cycle_cnt;
  rgb24_t        got_q[$];                             // Distinct colours seen
  rgb24_t        exp_q[$];                             // Expected colour order
  logic [15:0]   word_q[$];                            // Words written to FIFO
  rgb24_t        clut_model [`RTG_CLUT_ENTRIES];

  rtg_video_top i_dut (.*);

  initial begin
    clk_114 = 1'b0;
    forever #10 clk_114 = ~clk_114;
  end

  always @(posedge clk_114) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", LIMIT);
      $display("Test failures found");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Compare tasks and reference model

  task automatic check_video(input video_out_t got, input video_out_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_rgb(input rgb24_t got, input rgb24_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // RGB555 to 24 bits, top three bits repeated below
  function automatic rgb24_t hicolor_to_rgb(input logic [15:0] w);
    rgb24_t c;
    c.r = {w[14:10], w[14], w[13], w[12]};
    c.g = {w[9:5], w[9], w[8], w[7]};
    c.b = {w[4:0], w[4], w[3], w[2]};
    return c;
  endfunction

  function automatic rgb24_t osd_overlay(input rgb24_t c, input logic pix);
    rgb24_t o;
    o.r = {pix ? `RTG_OSD_SHADE_ON : `RTG_OSD_SHADE_OFF_RG, c.r[7:2]};
    o.g = {pix ? `RTG_OSD_SHADE_ON : `RTG_OSD_SHADE_OFF_RG, c.g[7:2]};
    o.b = {pix ? `RTG_OSD_SHADE_ON : `RTG_OSD_SHADE_OFF_B, c.b[7:2]};
    return o;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers

  task automatic pulse_vblank();
    @(posedge clk_114);
    native.vblank <= 1'b1;                             // Flush and restart frame
    repeat (2) @(posedge clk_114);
    native.vblank <= 1'b0;
    @(posedge clk_114);
    @(negedge clk_114);                                // Now in line counting
  endtask

  task automatic fill_until_full();
    int n;
    n = 0;
    word_q.delete();
    @(negedge clk_114);
    while (fill_req && n < `RTG_FIFO_DEPTH) begin
      @(posedge clk_114);
      fill      <= 1'b1;
      fill_data <= 16'h1234 + 16'(n * 16'h0421);       // Distinct neighbours
      word_q.push_back(16'h1234 + 16'(n * 16'h0421));
      @(posedge clk_114);
      fill      <= 1'b0;
      @(negedge clk_114);
      n++;
    end
  endtask

  task automatic hs_edges(input int n, input rgb24_t nat_rgb);
    repeat (n) begin
      @(posedge clk_114);
      native.hs <= 1'b1;
      @(negedge clk_114);
      check_rgb(video_out.rgb, nat_rgb, "native colour before active");
      @(posedge clk_114);
      native.hs <= 1'b0;
      @(negedge clk_114);
      check_rgb(video_out.rgb, nat_rgb, "native colour before active");
    end
  endtask

  task automatic collect_colours(input rgb24_t first);
    got_q.delete();
    got_q.push_back(first);
    repeat (COLLECT) begin
      @(negedge clk_114);
      if (video_out.rgb !== got_q[$]) got_q.push_back(video_out.rgb);
    end
  endtask

  // Expected order must appear back to back among the seen colours
  task automatic match_sequence(input string what);
    bit found;
    bit ok;
    found = 1'b0;
    for (int i = 0; i + exp_q.size() <= got_q.size() && !found; i++) begin
      ok = 1'b1;
      for (int j = 0; j < exp_q.size(); j++) begin
        if (got_q[i + j] !== exp_q[j]) ok = 1'b0;
      end
      found = ok;
    end
    checks++;
    if (!found || exp_q.size() == 0) begin
      errors++;
      $display("Error at %0t: %s colour order not seen on video_out", $time, what);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests

  task automatic test_passthrough();
    native_video_t v;
    video_out_t    e;
    for (int i = 0; i < N_RAND; i++) begin
      v = native_video_t'(29'($urandom));
      @(posedge clk_114);
      native <= v;
      @(posedge clk_114);
      @(negedge clk_114);
      e = {v.rgb, v.hs, v.vs, v.cs};
      check_video(video_out, e, "native passthrough");
      check_bit(pixel_strobe, 1'b1, "pixel_strobe with RTG off");
    end
  endtask

  task automatic test_osd();
    native_video_t v;
    video_out_t    e;
    logic          pix;
    for (int i = 0; i < N_RAND; i++) begin
      v   = native_video_t'(29'($urandom));
      pix = 1'($urandom);
      @(posedge clk_114);
      native     <= v;
      osd_window <= 1'b1;
      osd_pixel  <= pix;
      @(posedge clk_114);
      @(negedge clk_114);
      e = {osd_overlay(v.rgb, pix), v.hs, v.vs, v.cs};
      check_video(video_out, e, "OSD overlay");
    end
    @(posedge clk_114);
    osd_window <= 1'b0;
  endtask

  task automatic run_frame(input logic clut_mode, input rgb24_t nat_rgb);
    @(posedge clk_114);
    native     <= '0;
    native.rgb <= nat_rgb;
    cfg        <= '{ena: 1'b1, clut_mode: clut_mode, ext: 1'b0,
                    pixel_width: 4'd7, vb_end: 7'd3};
    pulse_vblank();
    fill_until_full();
    hs_edges(3, nat_rgb);
    collect_colours(nat_rgb);
  endtask

  task automatic test_hicolor();
    rgb24_t nat_rgb;
    nat_rgb = 24'h00ff00;
    exp_q.delete();
    run_frame(1'b0, nat_rgb);
    foreach (word_q[i]) exp_q.push_back(hicolor_to_rgb(word_q[i]));
    match_sequence("hi-colour");
  endtask

  task automatic test_clut();
    rgb24_t entry;
    rgb24_t nat_rgb;
    nat_rgb = 24'h123456;
    @(posedge clk_114);
    cfg.ena <= 1'b0;
    for (int i = 0; i < `RTG_CLUT_ENTRIES; i++) begin
      entry = {8'(i), 16'($urandom)};                  // Red byte keeps entries distinct
      @(posedge clk_114);
      clut_wr.we  <= 1'b1;
      clut_wr.idx <= 8'(i);
      clut_wr.rgb <= entry;
      clut_model[i] = entry;
    end
    @(posedge clk_114);
    clut_wr.we <= 1'b0;
    exp_q.delete();
    run_frame(1'b1, nat_rgb);
    foreach (word_q[i]) begin
      exp_q.push_back(clut_model[word_q[i][15:8]]);
      exp_q.push_back(clut_model[word_q[i][7:0]]);
    end
    match_sequence("CLUT");
  endtask

  task automatic test_fill_req();
    @(posedge clk_114);
    cfg.ena <= 1'b0;
    @(posedge clk_114);
    cfg <= '{ena: 1'b1, clut_mode: 1'b0, ext: 1'b0, pixel_width: 4'd7, vb_end: 7'd3};
    pulse_vblank();
    for (int i = 0; i < `RTG_FIFO_DEPTH / 2; i++) begin
      check_bit(fill_req, 1'b1, "fill_req below half depth");
      @(posedge clk_114);
      fill      <= 1'b1;
      fill_data <= 16'($urandom);
      @(posedge clk_114);
      fill      <= 1'b0;
      @(negedge clk_114);
    end
    check_bit(fill_req, 1'b0, "fill_req at half depth");
    pulse_vblank();                                    // Frame flush empties the FIFO
    check_bit(fill_req, 1'b1, "fill_req after frame flush");
    @(posedge clk_114);
    cfg.ena <= 1'b0;
    @(negedge clk_114);
    check_bit(fill_req, 1'b0, "fill_req with RTG off");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence

  initial begin
    void'($urandom(32'h1f33));
    errors     = 0;
    checks     = 0;
    cycle_cnt  = 0;
    arst_n     = 1'b0;
    cfg        = '0;
    native     = '0;
    osd_window = 1'b0;
    osd_pixel  = 1'b0;
    fill       = 1'b0;
    fill_data  = '0;
    clut_wr    = '0;
    repeat (4) @(posedge clk_114);
    @(negedge clk_114);
    check_video(video_out, '0, "video_out in reset");
    check_bit(fill_req, 1'b0, "fill_req in reset");
    check_bit(pixel_strobe, 1'b1, "pixel_strobe in reset");
    @(posedge clk_114);
    arst_n <= 1'b1;
    test_passthrough();
    test_osd();
    test_hicolor();
    test_clut();
    test_fill_req();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
